//--- vlog.f
verilog/glcm_pkg.sv
verilog/pixel_store.sv
verilog/glcm_ctrl.sv
verilog/pair_scanner.sv
verilog/cooc_counter.sv
verilog/glcm_top.sv
tests/glcm_properties.sv
tests/glcm_tb.sv

//--- Bender.yml
package:
  name: glcm_engine

sources:
  - files:
      - verilog/glcm_pkg.sv
      - verilog/pixel_store.sv
      - verilog/glcm_ctrl.sv
      - verilog/pair_scanner.sv
      - verilog/cooc_counter.sv
      - verilog/glcm_top.sv
  - target: test
    files:
      - tests/glcm_properties.sv
      - tests/glcm_tb.sv

//--- tests/glcm_tb.sv
/*
  Testbench for the GLCM engine. Loads LFSR images, runs jobs in all four
  directions and compares every drained count with a reference model.
*/
module glcm_tb
  import glcm_pkg::*;
();

  // a job is about 2300 cycles with the longest word gaps
  localparam int NUM_JOBS   = 5;
  localparam int JOB_CYCLES = 2600;
  localparam int MAX_CYCLES = NUM_JOBS * JOB_CYCLES;

  logic               clk = 1'b0;
  logic               rst_n;
  logic               in_valid;
  dir_t               in_dir;
  logic [DIS_W-1:0]   in_dis;
  logic               pix_valid;
  logic [WORD_W-1:0]  pix_word;
  logic               busy;
  logic               out_valid;
  logic [COUNT_W-1:0] out_count;
  logic               done;

  // image as the testbench sees it, row then column
  logic [LEVEL_W-1:0] img [IMG_DIM][IMG_DIM];
  int                 exp_count [NUM_BINS];
  logic [31:0]        lfsr_state;
  int                 errors;
  int                 tests;
  int                 cycles = 0;

  glcm_top dut0 (
    .clk, .rst_n, .in_valid, .in_dir, .in_dis,
    .pix_valid, .pix_word,
    .busy, .out_valid, .out_count, .done
  );

  always #4 clk = ~clk;

  // watchdog
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("timeout: the jobs did not finish within %0d cycles", MAX_CYCLES);
      $display("Checks failed");
      $finish;
    end
  end

  //////////////////////////////
  // stimulus helpers
  //////////////////////////////
  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic int unsigned rand_bits(input int n);
    int unsigned val;
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      val = (val << 1) | lfsr_state[0];
    end
    return val;
  endfunction

  task automatic fill_random();
    for (int r = 0; r < IMG_DIM; r++) begin
      for (int c = 0; c < IMG_DIM; c++) begin
        img[r][c] = LEVEL_W'(rand_bits(LEVEL_W));
      end
    end
  endtask

  task automatic fill_uniform(input logic [LEVEL_W-1:0] level);
    for (int r = 0; r < IMG_DIM; r++) begin
      for (int c = 0; c < IMG_DIM; c++) begin
        img[r][c] = level;
      end
    end
  endtask

  // neighbour offset in rows and columns for a direction code
  function automatic int row_offset(input dir_t dir, input int dis);
    return (dir == DIR_ROW || dir == DIR_DIAG) ? dis : 0;
  endfunction

  function automatic int col_offset(input dir_t dir, input int dis);
    return (dir == DIR_COL || dir == DIR_DIAG) ? dis : 0;
  endfunction

  // reference GLCM, out-of-image neighbours skipped
  function automatic void build_expected(input dir_t dir, input int dis);
    int dr;
    int dc;
    dr = row_offset(dir, dis);
    dc = col_offset(dir, dis);
    for (int b = 0; b < NUM_BINS; b++) exp_count[b] = 0;
    for (int r = 0; r + dr < IMG_DIM; r++) begin
      for (int c = 0; c + dc < IMG_DIM; c++) begin
        exp_count[img[r][c] * NUM_LEVELS + img[r + dr][c + dc]]++;
      end
    end
  endfunction

  // raster words, random junk above the 5 level bits of each lane
  task automatic send_image(input bit gaps);
    logic [WORD_W-1:0] word;
    int row;
    int col;
    for (int w = 0; w < NUM_WORDS; w++) begin
      if (gaps) repeat (rand_bits(2)) @(negedge clk);
      for (int k = 0; k < PIX_PER_WORD; k++) begin
        row = w / 4;
        col = 4 * (w % 4) + k;
        word[8*k +: 8] = {3'(rand_bits(3)), img[row][col]};
      end
      pix_word  = word;
      pix_valid = 1'b1;
      @(negedge clk);
      pix_valid = 1'b0;
    end
  endtask

  //////////////////////////////
  // one job, start to done
  //////////////////////////////
  task automatic run_job(input string name, input dir_t dir, input int dis, input bit gaps);
    int bin;
    int sum;
    int pairs;
    int errs_at_start;
    errs_at_start = errors;
    build_expected(dir, dis);
    pairs = (IMG_DIM - row_offset(dir, dis)) * (IMG_DIM - col_offset(dir, dis));
    in_valid = 1'b1;
    in_dir   = dir;
    in_dis   = DIS_W'(dis);
    @(negedge clk);
    in_valid = 1'b0;
    send_image(gaps);
    // drain start time depends on the clear and the scan
    while (!out_valid) @(negedge clk);
    bin = 0;
    sum = 0;
    while (out_valid) begin
      if (bin < NUM_BINS) begin
        assert (out_count == exp_count[bin]) else begin
          $display("FAIL %0t: %s bin %0d count %0d, expected %0d",
                   $time, name, bin, out_count, exp_count[bin]);
          errors++;
        end
        // self pairing only lands on the diagonal
        if (dir == DIR_SELF) begin
          assert (out_count == 0 || bin / NUM_LEVELS == bin % NUM_LEVELS) else begin
            $display("FAIL %0t: %s off-diagonal bin %0d holds %0d",
                     $time, name, bin, out_count);
            errors++;
          end
        end
        sum += out_count;
      end
      bin++;
      @(negedge clk);
    end
    assert (bin == NUM_BINS) else begin
      $display("FAIL %0t: %s drained %0d counts instead of %0d", $time, name, bin, NUM_BINS);
      errors++;
    end
    assert (sum == pairs) else begin
      $display("FAIL %0t: %s counts add up to %0d, expected %0d", $time, name, sum, pairs);
      errors++;
    end
    assert (done) else begin
      $display("FAIL %0t: %s has no done pulse right after the last count", $time, name);
      errors++;
    end
    while (busy) @(negedge clk);
    tests++;
    $display("test %0d %s: %s", tests, name, (errors == errs_at_start) ? "ok" : "mismatches");
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////
  initial begin
    lfsr_state = 32'hdd1e;
    errors     = 0;
    tests      = 0;
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    in_dir     = DIR_SELF;
    in_dis     = '0;
    pix_valid  = 1'b0;
    pix_word   = '0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    repeat (2) @(negedge clk);

    fill_random();
    run_job("random image, row offset 1", DIR_ROW, 1, 1'b1);
    run_job("column offset 7", DIR_COL, 7, 1'b1);
    // back-to-back words here
    run_job("diagonal offset 2", DIR_DIAG, 2, 1'b0);
    fill_random();
    // distance must be ignored for self pairing
    run_job("self pairing", DIR_SELF, 9, 1'b1);
    // one bin takes all 256 hits, and stale counts must be gone
    fill_uniform(5'd21);
    run_job("uniform image as later job", DIR_SELF, 0, 1'b0);

    repeat (4) @(negedge clk);
    $display("%0d tests, %0d value errors, %0d property failures",
             tests, errors, dut0.props0.prop_fails);
    if (errors == 0 && dut0.props0.prop_fails == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- tests/glcm_properties.sv
/*
  Concurrent timing checks on the GLCM top level ports. Bound into
  glcm_top; each failure bumps prop_fails and raises $error.
*/
module glcm_properties
  import glcm_pkg::*;
(
  input logic clk,
  input logic rst_n,
  input logic in_valid,
  input logic busy,
  input logic out_valid,
  input logic done
);

  int unsigned    prop_fails = 0;
  // length of the current out_valid run
  logic [BIN_W:0] run_len;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_len <= '0;
    end else if (out_valid) begin
      run_len <= run_len + 1'b1;
    end else begin
      run_len <= '0;
    end
  end

  //////////////////////////////
  // reset and count stream
  //////////////////////////////
  a_reset_quiet: assert property (@(posedge clk)
    $rose(rst_n) |-> !out_valid && !done && !busy)
    else begin prop_fails++; $error("outputs active right after reset"); end

  a_run_max: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> run_len < NUM_BINS)
    else begin prop_fails++; $error("out_valid run longer than 1024 cycles"); end

  // a finished run is exactly one full drain
  a_run_len: assert property (@(posedge clk) disable iff (!rst_n)
    (!out_valid && run_len != 0) |-> run_len == NUM_BINS)
    else begin prop_fails++; $error("out_valid run ended early"); end

  //////////////////////////////
  // done and busy
  //////////////////////////////
  a_done_after: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(out_valid) |-> done)
    else begin prop_fails++; $error("no done right after the count run"); end

  a_done_cause: assert property (@(posedge clk) disable iff (!rst_n)
    done |-> $past(out_valid) && !out_valid)
    else begin prop_fails++; $error("done without a count run just before"); end

  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    done |=> !done)
    else begin prop_fails++; $error("done longer than one cycle"); end

  a_busy_rise: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid && !busy |=> busy)
    else begin prop_fails++; $error("busy did not rise after job start"); end

  a_busy_hold: assert property (@(posedge clk) disable iff (!rst_n)
    busy && !done |=> busy)
    else begin prop_fails++; $error("busy dropped before done"); end

  // busy falls together with done
  a_busy_fall: assert property (@(posedge clk) disable iff (!rst_n)
    done |-> busy ##1 !busy)
    else begin prop_fails++; $error("busy not aligned with done"); end

endmodule

bind glcm_top glcm_properties props0 (
  .clk, .rst_n, .in_valid, .busy, .out_valid, .done
);

//--- verilog/glcm_top.sv
/*
  GLCM engine top level. Image words in, 1024 counts out in bin order,
  then a done pulse. Only instances and the wires between them.
*/
module glcm_top (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                in_valid,
  input  glcm_pkg::dir_t                      in_dir,
  input  logic [glcm_pkg::DIS_W-1:0]          in_dis,
  input  logic                                pix_valid,
  input  logic [glcm_pkg::WORD_W-1:0]         pix_word,
  output logic                                busy,
  output logic                                out_valid,
  output logic [glcm_pkg::COUNT_W-1:0]        out_count,
  output logic                                done
);

  // control handshakes
  logic load_en, load_done;
  logic clear_start, clear_done;
  logic scan_start, scan_done;
  logic drain_start, drain_done;

  // scanner to image store
  logic [glcm_pkg::POS_W-1:0]   ref_row, ref_col;
  logic [glcm_pkg::POS_W-1:0]   nbr_row, nbr_col;
  logic [glcm_pkg::LEVEL_W-1:0] ref_level, nbr_level;

  // pairs into the count array
  logic                         pair_valid;
  logic [glcm_pkg::BIN_W-1:0]   pair_bin;

  glcm_ctrl u_ctrl (
    .clk, .rst_n, .in_valid,
    .load_done, .clear_done, .scan_done, .drain_done,
    .busy, .done, .load_en,
    .clear_start, .scan_start, .drain_start
  );

  // producer side, image store and scanner
  pixel_store u_store (
    .clk, .rst_n, .load_en, .pix_valid, .pix_word,
    .ref_row, .ref_col, .nbr_row, .nbr_col,
    .ref_level, .nbr_level, .load_done
  );

  pair_scanner u_scan (
    .clk, .rst_n, .in_valid, .in_dir, .in_dis, .scan_start,
    .ref_level, .nbr_level,
    .ref_row, .ref_col, .nbr_row, .nbr_col,
    .pair_valid, .pair_bin, .scan_done
  );

  // count buffer plus drain consumer
  cooc_counter u_count (
    .clk, .rst_n, .clear_start, .drain_start,
    .pair_valid, .pair_bin,
    .clear_done, .out_valid, .out_count, .drain_done
  );

endmodule

//--- verilog/cooc_counter.sv
/*
  Count memory of the GLCM. Zeroed by a clear sweep, incremented through
  a two-stage read-modify-write, then streamed out by a drain sweep.
*/
module cooc_counter
  import glcm_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 clear_start,
  input  logic                 drain_start,
  input  logic                 pair_valid,
  input  logic [BIN_W-1:0]     pair_bin,
  output logic                 clear_done,
  output logic                 out_valid,
  output logic [COUNT_W-1:0]   out_count,
  output logic                 drain_done
);

  logic [COUNT_W-1:0] cnt_mem [NUM_BINS];
  logic               clearing;
  logic [BIN_W-1:0]   clr_addr;
  logic               drain_pend;
  logic               draining;
  logic [BIN_W-1:0]   drn_addr;
  logic               s1_valid;
  logic               s2_valid;
  logic [BIN_W-1:0]   s1_bin;
  logic [BIN_W-1:0]   s2_bin;
  logic [COUNT_W-1:0] s2_count;
  logic [BIN_W-1:0]   rd_addr;
  logic [COUNT_W-1:0] rd_data;
  logic [COUNT_W-1:0] base;
  logic [COUNT_W-1:0] inc_count;

  //////////////////////////////
  // array, one read one write
  //////////////////////////////
  // drain and scan never overlap, so one read port serves both
  assign rd_addr = draining ? drn_addr : pair_bin;

  always_ff @(posedge clk) begin
    rd_data <= cnt_mem[rd_addr];
    if (clearing) begin
      cnt_mem[clr_addr] <= '0;
    end else if (s1_valid) begin
      cnt_mem[s1_bin] <= inc_count;
    end
  end

  // forward when the previous pair hit the same bin
  // its write lands on the edge of our read
  assign base      = (s2_valid && (s2_bin == s1_bin)) ? s2_count : rd_data;
  assign inc_count = base + COUNT_W'(1);
  assign out_count = rd_data;

  always_ff @(posedge clk) begin
    s1_bin   <= pair_bin;
    s2_bin   <= s1_bin;
    s2_count <= inc_count;
  end

  // clear sweep
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      clearing   <= 1'b0;
      clr_addr   <= '0;
      clear_done <= 1'b0;
    end else begin
      clear_done <= clearing && (clr_addr == BIN_W'(NUM_BINS - 1));
      if (clear_start) begin
        clearing <= 1'b1;
        clr_addr <= '0;
      end else if (clearing) begin
        clr_addr <= clr_addr + 1'b1;
        if (clr_addr == BIN_W'(NUM_BINS - 1)) clearing <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // increment stages and drain
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid   <= 1'b0;
      s2_valid   <= 1'b0;
      drain_pend <= 1'b0;
      draining   <= 1'b0;
      drn_addr   <= '0;
      out_valid  <= 1'b0;
      drain_done <= 1'b0;
    end else begin
      s1_valid   <= pair_valid;
      s2_valid   <= s1_valid;
      // read data shows one cycle after its address
      out_valid  <= draining;
      drain_done <= draining && (drn_addr == BIN_W'(NUM_BINS - 1));
      if (drain_start) begin
        drain_pend <= 1'b1;
      end else if (drain_pend && !s1_valid && !s2_valid) begin
        // pipeline empty, start the sweep
        drain_pend <= 1'b0;
        draining   <= 1'b1;
        drn_addr   <= '0;
      end else if (draining) begin
        drn_addr <= drn_addr + 1'b1;
        if (drn_addr == BIN_W'(NUM_BINS - 1)) draining <= 1'b0;
      end
    end
  end

endmodule

//--- verilog/pair_scanner.sv
/*
  Walks all 256 pixel positions, one per cycle, and forms the neighbour
  at the job's offset. Emits a bin index for each in-range pair.
*/
module pair_scanner
  import glcm_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 in_valid,
  input  dir_t                 in_dir,
  input  logic [DIS_W-1:0]     in_dis,
  input  logic                 scan_start,
  input  logic [LEVEL_W-1:0]   ref_level,
  input  logic [LEVEL_W-1:0]   nbr_level,
  output logic [POS_W-1:0]     ref_row,
  output logic [POS_W-1:0]     ref_col,
  output logic [POS_W-1:0]     nbr_row,
  output logic [POS_W-1:0]     nbr_col,
  output logic                 pair_valid,
  output logic [BIN_W-1:0]     pair_bin,
  output logic                 scan_done
);

  dir_t               dir_q;
  logic [DIS_W-1:0]   dis_q;
  logic               scanning;
  logic [2*POS_W-1:0] pos;
  logic               row_step;
  logic               col_step;
  logic [POS_W:0]     nbr_r_ext;
  logic [POS_W:0]     nbr_c_ext;
  logic               in_range;

  // job config, held for the whole job
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dir_q <= DIR_SELF;
      dis_q <= '0;
    end else if (in_valid) begin
      dir_q <= in_dir;
      dis_q <= in_dis;
    end
  end

  assign row_step = (dir_q == DIR_ROW) || (dir_q == DIR_DIAG);
  assign col_step = (dir_q == DIR_COL) || (dir_q == DIR_DIAG);

  // position counter is raster order {row, col}
  assign ref_row = pos[2*POS_W-1:POS_W];
  assign ref_col = pos[POS_W-1:0];

  // extra top bit catches a step past the image edge
  assign nbr_r_ext = {1'b0, ref_row} + (row_step ? {1'b0, dis_q} : '0);
  assign nbr_c_ext = {1'b0, ref_col} + (col_step ? {1'b0, dis_q} : '0);
  assign in_range  = (nbr_r_ext < IMG_DIM) && (nbr_c_ext < IMG_DIM);
  assign nbr_row   = nbr_r_ext[POS_W-1:0];
  assign nbr_col   = nbr_c_ext[POS_W-1:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      scanning   <= 1'b0;
      pos        <= '0;
      pair_valid <= 1'b0;
      scan_done  <= 1'b0;
    end else begin
      pair_valid <= scanning && in_range;
      scan_done  <= scanning && (pos == '1);
      if (scan_start) begin
        scanning <= 1'b1;
        pos      <= '0;
      end else if (scanning) begin
        pos <= pos + 1'b1;
        // last position reached
        if (pos == '1) scanning <= 1'b0;
      end
    end
  end

  // bin = ref * 32 + nbr
  always_ff @(posedge clk) begin
    pair_bin <= BIN_W'(ref_level) * BIN_W'(NUM_LEVELS) + BIN_W'(nbr_level);
  end

endmodule

//--- verilog/glcm_ctrl.sv
/*
  Job FSM. Starts the count clear at job start, waits for both image load
  and clear, then runs the pair scan and the result drain.
*/
module glcm_ctrl
  import glcm_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic in_valid,
  input  logic load_done,
  input  logic clear_done,
  input  logic scan_done,
  input  logic drain_done,
  output logic busy,
  output logic done,
  output logic load_en,
  output logic clear_start,
  output logic scan_start,
  output logic drain_start
);

  ctrl_state_t state;
  ctrl_state_t state_nxt;
  logic        load_seen;
  logic        clear_seen;
  logic        load_ok;
  logic        clear_ok;

  // a pulse in the current cycle counts as seen
  assign load_ok  = load_seen | load_done;
  assign clear_ok = clear_seen | clear_done;

  //////////////////////////////
  // next state
  //////////////////////////////
  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE:  if (in_valid) state_nxt = ST_LOAD;
      ST_LOAD:  if (load_ok && clear_ok) state_nxt = ST_SCAN;
      ST_SCAN:  if (scan_done) state_nxt = ST_DRAIN;
      ST_DRAIN: if (drain_done) state_nxt = ST_DONE;
      ST_DONE:  state_nxt = ST_IDLE;
      default:  state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // load and clear finish in either order
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      load_seen  <= 1'b0;
      clear_seen <= 1'b0;
    end else if (state_nxt == ST_SCAN && state == ST_LOAD) begin
      load_seen  <= 1'b0;
      clear_seen <= 1'b0;
    end else if (state == ST_LOAD) begin
      load_seen  <= load_ok;
      clear_seen <= clear_ok;
    end
  end

  //////////////////////////////
  // start pulses
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      scan_start  <= 1'b0;
      drain_start <= 1'b0;
    end else begin
      scan_start  <= (state == ST_LOAD) && (state_nxt == ST_SCAN);
      drain_start <= (state == ST_SCAN) && scan_done;
    end
  end

  // clear sweep begins right at the accepted start
  assign clear_start = (state == ST_IDLE) && in_valid;
  assign load_en     = (state == ST_LOAD);
  // busy drops together with done
  assign busy        = (state != ST_IDLE);
  assign done        = (state == ST_DONE);

endmodule

//--- verilog/pixel_store.sv
/*
  Register file for the 16x16 image. Words are unpacked four pixels at a
  time in raster order; two combinational read ports feed the pair scanner.
*/
module pixel_store
  import glcm_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 load_en,
  input  logic                 pix_valid,
  input  logic [WORD_W-1:0]    pix_word,
  input  logic [POS_W-1:0]     ref_row,
  input  logic [POS_W-1:0]     ref_col,
  input  logic [POS_W-1:0]     nbr_row,
  input  logic [POS_W-1:0]     nbr_col,
  output logic [LEVEL_W-1:0]   ref_level,
  output logic [LEVEL_W-1:0]   nbr_level,
  output logic                 load_done
);

  // one cell per pixel, index is row*16 + col
  logic [LEVEL_W-1:0]           cells [IMG_DIM*IMG_DIM];
  logic [$clog2(NUM_WORDS)-1:0] word_cnt;
  logic                         word_acc;

  // words only count while the job is loading
  assign word_acc = load_en && pix_valid;

  // word counter wraps to zero after the 64th word
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      word_cnt  <= '0;
      load_done <= 1'b0;
    end else begin
      load_done <= word_acc && (word_cnt == '1);
      if (word_acc) begin
        word_cnt <= word_cnt + 1'b1;
      end
    end
  end

  // unpack lanes, pixel sits in the low bits of each byte
  always_ff @(posedge clk) begin
    if (word_acc) begin
      for (int k = 0; k < PIX_PER_WORD; k++) begin
        cells[word_cnt*PIX_PER_WORD + k] <=
          pix_word[k*(WORD_W/PIX_PER_WORD) +: LEVEL_W];
      end
    end
  end

  // raster index is just {row, col}
  assign ref_level = cells[{ref_row, ref_col}];
  assign nbr_level = cells[{nbr_row, nbr_col}];

endmodule

//--- verilog/glcm_pkg.sv
/*
  Shared sizes, bin arithmetic constants and enums for the GLCM engine.
  Imported by wildcard into every block that needs them.
*/
package glcm_pkg;

  //////////////////////////////
  // image geometry
  //////////////////////////////
  localparam int IMG_DIM      = 16;
  localparam int POS_W        = 4;
  localparam int DIS_W        = 4;

  // image words, four byte lanes each
  localparam int WORD_W       = 32;
  localparam int PIX_PER_WORD = 4;
  localparam int NUM_WORDS    = 64;

  //////////////////////////////
  // gray levels and bins
  //////////////////////////////
  localparam int LEVEL_W      = 5;
  localparam int NUM_LEVELS   = 32;
  // bin = ref level * NUM_LEVELS + neighbour level
  localparam int NUM_BINS     = 1024;
  localparam int BIN_W        = 10;
  // 9 bits so that 256 hits on one bin still fit
  localparam int COUNT_W      = 9;

  // offset direction of the neighbour pixel
  typedef enum logic [1:0] {
    DIR_SELF = 2'b00,
    DIR_ROW  = 2'b01,
    DIR_COL  = 2'b10,
    DIR_DIAG = 2'b11
  } dir_t;

  // job sequencing
  typedef enum logic [2:0] {
    ST_IDLE  = 3'd0,
    ST_LOAD  = 3'd1,
    ST_SCAN  = 3'd2,
    ST_DRAIN = 3'd3,
    ST_DONE  = 3'd4
  } ctrl_state_t;

endpackage
